/* include/avmm_cross_consts.svh */
// Width, FIFO depth and almost-full threshold macros for the Avalon clock-crossing bridge
`ifndef AVMM_CROSS_CONSTS_SVH
`define AVMM_CROSS_CONSTS_SVH

// Word address width on both sides of the bridge
`define avmm_addr_width 16

// Data bus width in bits, always a whole number of bytes
`define avmm_data_width 32

// Burst count width that holds bursts of 1 to 4 beats
`define avmm_burst_width 3

// Command FIFO depth in entries
// Each accepted request or write beat takes one entry
`define avmm_cmd_fifo_depth 16

// Response FIFO depth is twice the longest read burst
// Two full bursts may then sit in flight at once
`define avmm_rsp_fifo_depth 8

// Avalon response code width
`define avmm_resp_width 2

// Default almost-full threshold on the shim
// Zero keeps the plain Avalon waitrequest rule
`define avmm_almfull_threshold 0

`endif

/* source/avmm_cross_pkg.sv */
// Vector types for address, data, byte enables, burst count, response and FIFO level
`include "avmm_cross_consts.svh"

package avmm_cross_pkg;

    // Word address as seen by master and slave
    typedef logic [`avmm_addr_width-1:0] addr_t;

    // Read and write data
    typedef logic [`avmm_data_width-1:0] data_t;

    // One enable bit for every byte lane of the data bus
    typedef logic [`avmm_data_width/8-1:0] byteen_t;

    // Burst length in beats, never zero on a valid request
    typedef logic [`avmm_burst_width-1:0] burst_t;

    // Response code where 0 is okay and 2 is slave error
    typedef logic [`avmm_resp_width-1:0] resp_t;

    // FIFO fill or space count
    // One bit wider than the log2 of the command depth so a full count fits
    typedef logic [$clog2(`avmm_cmd_fifo_depth):0] level_t;

endpackage

/* source/async_fifo.sv */
// Dual-clock FIFO with Gray-coded pointers, write-side full and space, read-side empty
module async_fifo
    import avmm_cross_pkg::*;
#(
    parameter int depth = 16,
    parameter int width = 8
)
(
    // Write domain
    input  logic             wr_clk,
    input  logic             wr_rst,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    output logic             full,
    output level_t           space,

    // Read domain
    input  logic             rd_clk,
    input  logic             rd_rst,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             empty
);

    // Pointers carry one extra bit to tell a full FIFO from an empty one
    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];

    logic [aw:0] wr_bin;
    logic [aw:0] wr_bin_next;
    logic [aw:0] wr_gray;
    logic [aw:0] rd_gray_s1;
    logic [aw:0] rd_gray_s2;
    logic [aw:0] rd_bin_s;
    logic [aw:0] wr_used;
    logic        wr_go;

    logic [aw:0] rd_bin;
    logic [aw:0] rd_bin_next;
    logic [aw:0] rd_gray;
    logic [aw:0] wr_gray_s1;
    logic [aw:0] wr_gray_s2;
    logic        rd_go;

    // Gray to binary conversion where each bit is the XOR of all Gray bits at and above it
    function automatic logic [aw:0] gray_to_bin(input logic [aw:0] g);
        logic [aw:0] b;
        b[aw] = g[aw];
        for (int i = aw - 1; i >= 0; i--)
        begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // Writes that arrive while full are dropped here
    // The shim never lets that happen
    assign wr_go       = wr_en && !full;
    assign wr_bin_next = wr_bin + (aw + 1)'(wr_go);

    always_ff @(posedge wr_clk)
    begin
        if (wr_rst)
        begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end
        else
        begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    // One entry is stored per accepted write
    always_ff @(posedge wr_clk)
    begin
        if (wr_go)
        begin
            mem[wr_bin[aw-1:0]] <= wr_data;
        end
    end

    // Read pointer enters the write domain through two flops
    always_ff @(posedge wr_clk)
    begin
        if (wr_rst)
        begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end
        else
        begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Fill level is pessimistic by the synchronizer delay, which is safe for a writer
    assign rd_bin_s = gray_to_bin(rd_gray_s2);
    assign wr_used  = wr_bin - rd_bin_s;
    assign full     = (wr_used == (aw + 1)'(depth));
    assign space    = level_t'(depth) - level_t'(wr_used);

    // Write pointer enters the read domain through two flops
    always_ff @(posedge rd_clk)
    begin
        if (rd_rst)
        begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end
        else
        begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // Equal Gray pointers mean nothing is left to read
    assign empty       = (rd_gray == wr_gray_s2);
    assign rd_go       = rd_en && !empty;
    assign rd_bin_next = rd_bin + (aw + 1)'(rd_go);

    always_ff @(posedge rd_clk)
    begin
        if (rd_rst)
        begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end
        else
        begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    // The head entry is on rd_data whenever empty is low
    assign rd_data = mem[rd_bin[aw-1:0]];

endmodule

/* source/avmm_clock_crossing_bridge.sv */
// Command and response FIFOs, slave reset synchronizer, slave command issue and read credits
`include "avmm_cross_consts.svh"

module avmm_clock_crossing_bridge
    import avmm_cross_pkg::*;
(
    // Master side, mem_master domain
    input  logic    mem_master,
    input  logic    rst,
    input  addr_t   m_address,
    input  burst_t  m_burstcount,
    input  logic    m_read,
    input  logic    m_write,
    input  data_t   m_writedata,
    input  byteen_t m_byteenable,
    input  logic    m_push,
    output logic    cmd_full,
    output level_t  cmd_space,
    output data_t   m_readdata,
    output resp_t   m_response,
    output logic    m_readdatavalid,

    // Slave side, mem_slave domain
    input  logic    mem_slave,
    input  logic    s_waitrequest,
    input  data_t   s_readdata,
    input  resp_t   s_response,
    input  logic    s_readdatavalid,
    output addr_t   s_address,
    output burst_t  s_burstcount,
    output logic    s_read,
    output logic    s_write,
    output data_t   s_writedata,
    output byteen_t s_byteenable
);

    // Command entry is {read, write, address, burstcount, byteenable, writedata}
    localparam int cmd_width = 2 + $bits(addr_t) + $bits(burst_t) + $bits(byteen_t)
                               + $bits(data_t);

    // Response entry is {response, readdata}
    localparam int rsp_width = $bits(resp_t) + $bits(data_t);

    logic                 s_rst_meta;
    logic                 s_rst;

    logic [cmd_width-1:0] cmd_wr_data;
    logic [cmd_width-1:0] cmd_rd_data;
    logic                 cmd_empty;
    logic                 cmd_pop;
    logic                 head_read;
    logic                 head_write;

    logic [rsp_width-1:0] rsp_wr_data;
    logic [rsp_width-1:0] rsp_rd_data;
    logic                 rsp_empty;
    level_t               rsp_space;

    level_t               pend_beats;
    logic                 rd_room;
    logic                 rd_accept;

    // rst is a mem_master signal, so it is brought into mem_slave through two flops
    // The slave side leaves reset a few cycles after the master side
    always_ff @(posedge mem_slave)
    begin
        s_rst_meta <= rst;
        s_rst      <= s_rst_meta;
    end

    // Every accepted master beat becomes one command entry
    // Write burst beats each carry their own data and byte enables
    assign cmd_wr_data = {m_read, m_write, m_address, m_burstcount, m_byteenable, m_writedata};

    async_fifo #(
        .depth (`avmm_cmd_fifo_depth),
        .width (cmd_width)
    ) cmd_fifo_i (
        .wr_clk  (mem_master),
        .wr_rst  (rst),
        .wr_en   (m_push),
        .wr_data (cmd_wr_data),
        .full    (cmd_full),
        .space   (cmd_space),
        .rd_clk  (mem_slave),
        .rd_rst  (s_rst),
        .rd_en   (cmd_pop),
        .rd_data (cmd_rd_data),
        .empty   (cmd_empty)
    );

    // The FIFO head drives the slave bus directly
    assign {head_read, head_write, s_address, s_burstcount, s_byteenable, s_writedata} =
        cmd_rd_data;

    // pend_beats counts read beats the slave still owes
    // Beats already in the response FIFO are covered by its space count,
    // so a read goes out only when everything owed plus this burst fits
    assign rd_room = (pend_beats + level_t'(s_burstcount)) <= rsp_space;

    // Once rd_room is true it stays true until the read is taken
    // A returned beat lowers both sides of the compare and a master pop raises space
    assign s_read  = !cmd_empty && head_read && rd_room;
    assign s_write = !cmd_empty && head_write;

    // A held read also holds every write behind it, so order is kept
    assign rd_accept = s_read && !s_waitrequest;
    assign cmd_pop   = (s_read || s_write) && !s_waitrequest;

    always_ff @(posedge mem_slave)
    begin
        if (s_rst)
        begin
            pend_beats <= '0;
        end
        else
        begin
            pend_beats <= pend_beats
                          + (rd_accept ? level_t'(s_burstcount) : level_t'(0))
                          - level_t'(s_readdatavalid);
        end
    end

    // Response code travels packed beside the read data
    assign rsp_wr_data = {s_response, s_readdata};

    // The credit check keeps this FIFO from ever filling, so its full flag is not needed
    async_fifo #(
        .depth (`avmm_rsp_fifo_depth),
        .width (rsp_width)
    ) rsp_fifo_i (
        .wr_clk  (mem_slave),
        .wr_rst  (s_rst),
        .wr_en   (s_readdatavalid),
        .wr_data (rsp_wr_data),
        .full    (),
        .space   (rsp_space),
        .rd_clk  (mem_master),
        .rd_rst  (rst),
        .rd_en   (m_readdatavalid),
        .rd_data (rsp_rd_data),
        .empty   (rsp_empty)
    );

    // The master cannot stall read data, so every waiting beat is popped at once
    assign m_readdatavalid          = !rsp_empty;
    assign {m_response, m_readdata} = rsp_rd_data;

endmodule

/* source/avmm_async_shim.sv */
// Top level Avalon clock-crossing shim with plain or almost-full master waitrequest
`include "avmm_cross_consts.svh"

module avmm_async_shim
    import avmm_cross_pkg::*;
#(
    // Nonzero lets the master issue this many more requests after waitrequest rises
    parameter int almfull_threshold = `avmm_almfull_threshold
)
(
    input  logic    mem_master,
    input  logic    mem_slave,
    input  logic    rst,

    // Master port, mem_master domain
    input  addr_t   address,
    input  burst_t  burstcount,
    input  logic    read,
    input  logic    write,
    input  data_t   writedata,
    input  byteen_t byteenable,
    output logic    waitrequest,
    output data_t   readdata,
    output resp_t   response,
    output logic    readdatavalid,

    // Slave port, mem_slave domain
    output addr_t   s_address,
    output burst_t  s_burstcount,
    output logic    s_read,
    output logic    s_write,
    output data_t   s_writedata,
    output byteen_t s_byteenable,
    input  logic    s_waitrequest,
    input  data_t   s_readdata,
    input  resp_t   s_response,
    input  logic    s_readdatavalid
);

    logic   cmd_full;
    level_t cmd_space;
    logic   m_push;

    // The command FIFO takes anything offered while it has room
    // In plain mode this is exactly read or write with waitrequest low
    // In almost-full mode it also takes the requests that overrun waitrequest
    assign m_push = (read || write) && !cmd_full;

    avmm_clock_crossing_bridge bridge_i (
        .mem_master      (mem_master),
        .rst             (rst),
        .m_address       (address),
        .m_burstcount    (burstcount),
        .m_read          (read),
        .m_write         (write),
        .m_writedata     (writedata),
        .m_byteenable    (byteenable),
        .m_push          (m_push),
        .cmd_full        (cmd_full),
        .cmd_space       (cmd_space),
        .m_readdata      (readdata),
        .m_response      (response),
        .m_readdatavalid (readdatavalid),
        .mem_slave       (mem_slave),
        .s_waitrequest   (s_waitrequest),
        .s_readdata      (s_readdata),
        .s_response      (s_response),
        .s_readdatavalid (s_readdatavalid),
        .s_address       (s_address),
        .s_burstcount    (s_burstcount),
        .s_read          (s_read),
        .s_write         (s_write),
        .s_writedata     (s_writedata),
        .s_byteenable    (s_byteenable)
    );

    generate
        if (almfull_threshold == 0)
        begin : g_plain
            // Under the usual Avalon rule waitrequest follows FIFO full in the same cycle
            assign waitrequest = cmd_full;
        end
        else
        begin : g_almfull
            // Registered almost-full flag taken from the space left after this cycle's push
            // When it is seen high at least almfull_threshold slots still remain
            // Held high in reset so the master waits for the FIFO to come up
            always_ff @(posedge mem_master)
            begin
                if (rst)
                begin
                    waitrequest <= 1'b1;
                end
                else
                begin
                    waitrequest <= ((cmd_space - level_t'(m_push))
                                    <= level_t'(almfull_threshold));
                end
            end
        end
    endgenerate

endmodule

/* test/avmm_mem_model.sv */
// Avalon slave memory model with random waitrequest, variable read latency and error responses
module avmm_mem_model
    import avmm_cross_pkg::*;
(
    input  logic    mem_slave,
    input  logic    rst,
    input  logic    hold,
    input  addr_t   s_address,
    input  burst_t  s_burstcount,
    input  logic    s_read,
    input  logic    s_write,
    input  data_t   s_writedata,
    input  byteen_t s_byteenable,
    output logic    s_waitrequest,
    output data_t   s_readdata,
    output resp_t   s_response,
    output logic    s_readdatavalid,
    output int      write_beats
);

    timeunit 1ns;
    timeprecision 100ps;

    // Words never written read back as a pattern of their own address
    data_t mem [addr_t];

    // Read beats waiting to be returned, with the slave cycle each one is due
    addr_t beat_addr [$];
    int    beat_due [$];

    int    cycle;
    int    last_due;
    addr_t wr_base;
    int    wr_idx;
    int    wr_left;

    function automatic data_t word_at(input addr_t a);
        if (mem.exists(a))
        begin
            return mem[a];
        end
        return {a ^ 16'h3c5a, ~a};
    endfunction

    initial
    begin
        s_waitrequest   = 1'b0;
        s_readdata      = '0;
        s_response      = '0;
        s_readdatavalid = 1'b0;
        write_beats     = 0;
    end

    always @(posedge mem_slave)
    begin
        data_t w;
        addr_t a;
        int    due;
        if (rst)
        begin
            cycle    = 0;
            last_due = 0;
            wr_left  = 0;
            beat_addr.delete();
            beat_due.delete();
            write_beats = 0;
            #1;
            s_waitrequest   = 1'b0;
            s_readdatavalid = 1'b0;
        end
        else
        begin
            cycle++;
            // A write burst takes its address from the first beat only
            if (s_write && !s_waitrequest)
            begin
                if (wr_left == 0)
                begin
                    wr_base = s_address;
                    wr_idx  = 0;
                    wr_left = s_burstcount;
                end
                a = wr_base + addr_t'(wr_idx);
                w = word_at(a);
                for (int b = 0; b < $bits(byteen_t); b++)
                begin
                    if (s_byteenable[b])
                    begin
                        w[8*b +: 8] = s_writedata[8*b +: 8];
                    end
                end
                mem[a] = w;
                wr_idx++;
                wr_left--;
                write_beats++;
            end
            // First beat comes back after 1 to 5 cycles, the rest follow in order
            if (s_read && !s_waitrequest)
            begin
                due = cycle + $urandom_range(1, 5);
                for (int i = 0; i < s_burstcount; i++)
                begin
                    if (due <= last_due)
                    begin
                        due = last_due + 1;
                    end
                    beat_addr.push_back(s_address + addr_t'(i));
                    beat_due.push_back(due);
                    last_due = due;
                end
            end
            #1;
            s_waitrequest = hold || ($urandom_range(0, 2) == 0);
            if (beat_due.size() > 0 && beat_due[0] <= cycle)
            begin
                a = beat_addr.pop_front();
                void'(beat_due.pop_front());
                s_readdata      = word_at(a);
                s_response      = (a >= 16'hf000) ? resp_t'(2) : resp_t'(0);
                s_readdatavalid = 1'b1;
            end
            else
            begin
                s_readdatavalid = 1'b0;
            end
        end
    end

endmodule

/* test/tb_avmm_cross.sv */
// Testbench for the Avalon clock-crossing shim in plain and almost-full waitrequest modes
module tb_avmm_cross
    import avmm_cross_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Requests the almost-full master may still issue after waitrequest rises
    localparam int af_threshold = 4;

    logic mem_master = 1'b0;
    logic mem_slave = 1'b0;
    logic rst;
    logic hold;
    addr_t address;
    burst_t burstcount;
    data_t writedata;
    byteen_t byteenable;
    logic read_p, write_p, read_af, write_af;
    logic wreq_p, wreq_af, rdv_p, rdv_af;
    data_t rdata_p, rdata_af;
    resp_t resp_p, resp_af;

    // Each DUT drives its own slave bus
    addr_t sa_p, sa_af;
    burst_t sbc_p, sbc_af;
    logic sr_p, sr_af, sw_p, sw_af, swr_p, swr_af, srdv_p, srdv_af;
    data_t swd_p, swd_af, srd_p, srd_af;
    byteen_t sbe_p, sbe_af;
    resp_t srsp_p, srsp_af;
    int wb_p, wb_af;

    // Reference memory and the beats each DUT still owes
    // Each expected beat is packed as {response, data}
    data_t ref_mem [addr_t];
    logic [33:0] exp_p [$];
    logic [33:0] exp_af [$];
    int issued, write_beats_issued, cyc, overrun;
    logic started;

    always #10 mem_master = ~mem_master;
    always #7 mem_slave = ~mem_slave;

    avmm_async_shim #(.almfull_threshold(0)) dut_i (
        .mem_master(mem_master), .mem_slave(mem_slave), .rst(rst),
        .address(address), .burstcount(burstcount), .read(read_p), .write(write_p),
        .writedata(writedata), .byteenable(byteenable), .waitrequest(wreq_p),
        .readdata(rdata_p), .response(resp_p), .readdatavalid(rdv_p),
        .s_address(sa_p), .s_burstcount(sbc_p), .s_read(sr_p), .s_write(sw_p),
        .s_writedata(swd_p), .s_byteenable(sbe_p), .s_waitrequest(swr_p),
        .s_readdata(srd_p), .s_response(srsp_p), .s_readdatavalid(srdv_p)
    );

    avmm_async_shim #(.almfull_threshold(af_threshold)) dut_af_i (
        .mem_master(mem_master), .mem_slave(mem_slave), .rst(rst),
        .address(address), .burstcount(burstcount), .read(read_af), .write(write_af),
        .writedata(writedata), .byteenable(byteenable), .waitrequest(wreq_af),
        .readdata(rdata_af), .response(resp_af), .readdatavalid(rdv_af),
        .s_address(sa_af), .s_burstcount(sbc_af), .s_read(sr_af), .s_write(sw_af),
        .s_writedata(swd_af), .s_byteenable(sbe_af), .s_waitrequest(swr_af),
        .s_readdata(srd_af), .s_response(srsp_af), .s_readdatavalid(srdv_af)
    );

    avmm_mem_model mdl_p_i (
        .mem_slave(mem_slave), .rst(rst), .hold(hold), .s_address(sa_p),
        .s_burstcount(sbc_p), .s_read(sr_p), .s_write(sw_p), .s_writedata(swd_p),
        .s_byteenable(sbe_p), .s_waitrequest(swr_p), .s_readdata(srd_p),
        .s_response(srsp_p), .s_readdatavalid(srdv_p), .write_beats(wb_p)
    );

    avmm_mem_model mdl_af_i (
        .mem_slave(mem_slave), .rst(rst), .hold(hold), .s_address(sa_af),
        .s_burstcount(sbc_af), .s_read(sr_af), .s_write(sw_af), .s_writedata(swd_af),
        .s_byteenable(sbe_af), .s_waitrequest(swr_af), .s_readdata(srd_af),
        .s_response(srsp_af), .s_readdatavalid(srdv_af), .write_beats(wb_af)
    );

    task automatic halt_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("%0t: %s", $time, what);
        halt_run();
    endtask

    task automatic report_mismatch(input string sig, input logic [63:0] exp, act);
        $display("ERR %0t %s expected %0h actual %0h", $time, sig, exp, act);
        halt_run();
    endtask

    // Untouched memory holds a pattern built from the whole address
    function automatic data_t ref_word(input addr_t a);
        if (ref_mem.exists(a))
        begin
            return ref_mem[a];
        end
        return {a ^ 16'h3c5a, ~a};
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t d, input byteen_t be);
        data_t w;
        w = old;
        for (int b = 0; b < $bits(byteen_t); b++)
        begin
            if (be[b])
            begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        return w;
    endfunction

    // Nothing may come out of either DUT before the first command
    idle_master_chk: assert property (@(posedge mem_master)
        (cyc > 2 && !started) |-> !(rdv_p || rdv_af))
        else report_mismatch("readdatavalid", 0, 1);
    idle_slave_chk: assert property (@(posedge mem_slave)
        (cyc > 4 && !started) |-> !(sr_p || sw_p || sr_af || sw_af))
        else report_mismatch("s_read/s_write", 0, 1);
    af_reset_chk: assert property (@(posedge mem_master) rst |=> wreq_af)
        else report_mismatch("waitrequest(dut_af_i)", 1, wreq_af);

    task automatic check_beat(ref logic [33:0] q[$], input resp_t r, input data_t d,
                              input string which);
        logic [33:0] e;
        beat_pending_chk: assert (q.size() > 0)
            else report_error({which, " returned a read beat with no read pending"});
        e = q.pop_front();
        resp_chk: assert (r == e[33:32])
            else report_mismatch({"response(", which, ")"}, e[33:32], r);
        data_chk: assert (d == e[31:0])
            else report_mismatch({"readdata(", which, ")"}, e[31:0], d);
    endtask

    always @(posedge mem_master)
    begin
        if (!rst && rdv_p)
        begin
            check_beat(exp_p, resp_p, rdata_p, "dut_i");
        end
        if (!rst && rdv_af)
        begin
            check_beat(exp_af, resp_af, rdata_af, "dut_af_i");
        end
    end

    // Run limit grows with the number of commands issued so far
    always @(posedge mem_master)
    begin
        cyc++;
        if (cyc > 200 * issued + 500)
        begin
            report_error("timeout, the DUTs stopped making progress");
        end
    end

    // Offers one beat to both DUTs until each has taken it
    // The almost-full master keeps going for up to af_threshold requests past waitrequest
    // and drops its request while it waits
    task automatic send(input logic is_read, input addr_t a, input burst_t bc,
                        input data_t d, input byteen_t be);
        logic done_p, done_af, acc_p, acc_af;
        done_p = 1'b0;
        done_af = 1'b0;
        address = a;
        burstcount = bc;
        writedata = d;
        byteenable = be;
        started = 1'b1;
        issued++;
        while (!(done_p && done_af))
        begin
            acc_p = !done_p && !wreq_p;
            acc_af = !done_af && (!wreq_af || overrun < af_threshold);
            read_p = is_read && !done_p;
            write_p = !is_read && !done_p;
            read_af = is_read && acc_af;
            write_af = !is_read && acc_af;
            if (!wreq_af)
            begin
                overrun = 0;
            end
            else if (acc_af)
            begin
                overrun++;
            end
            overrun_chk: assert (!acc_af || !dut_af_i.bridge_i.cmd_full)
                else report_error("almost-full master overran a full command FIFO");
            @(posedge mem_master);
            #2;
            done_p = done_p || acc_p;
            done_af = done_af || acc_af;
        end
        read_p = 1'b0;
        write_p = 1'b0;
        read_af = 1'b0;
        write_af = 1'b0;
        if (!is_read)
        begin
            write_beats_issued++;
        end
    endtask

    task automatic write_burst(input addr_t a, input int n);
        data_t d;
        byteen_t be;
        for (int i = 0; i < n; i++)
        begin
            d = $urandom();
            be = $urandom();
            ref_mem[a + addr_t'(i)] = merge_bytes(ref_word(a + addr_t'(i)), d, be);
            send(1'b0, a, burst_t'(n), d, be);
        end
    endtask

    task automatic read_burst(input addr_t a, input int n);
        addr_t b;
        resp_t r;
        for (int i = 0; i < n; i++)
        begin
            b = a + addr_t'(i);
            r = (b >= 16'hf000) ? resp_t'(2) : resp_t'(0);
            exp_p.push_back({r, ref_word(b)});
            exp_af.push_back({r, ref_word(b)});
        end
        send(1'b1, a, burst_t'(n), '0, '1);
    endtask

    initial
    begin
        addr_t a;
        void'($urandom(32'hbb2a864d));
        {rst, hold, started} = 3'b100;
        {read_p, write_p, read_af, write_af} = '0;
        {address, burstcount, writedata, byteenable} = '0;
        {issued, write_beats_issued, cyc, overrun} = '0;
        repeat (16) @(posedge mem_master);
        #2 rst = 1'b0;
        repeat (8) @(posedge mem_master);
        #2;
        // Byte-enabled writes each read straight back
        for (int i = 0; i < 8; i++)
        begin
            a = $urandom() & 16'h0fff;
            write_burst(a, 1);
            read_burst(a, 1);
        end
        // Random bursts under full slave stall at the start
        hold = 1'b1;
        fork
            begin
                repeat (40) @(posedge mem_master);
                hold = 1'b0;
            end
        join_none
        for (int i = 0; i < 20; i++)
        begin
            read_burst(16'h1000 + addr_t'($urandom_range(0, 255)), $urandom_range(1, 4));
        end
        // Error region and normal region
        for (int i = 0; i < 8; i++)
        begin
            a = (i % 2) ? 16'hf000 + addr_t'($urandom_range(0, 64))
                        : addr_t'($urandom_range(0, 64));
            read_burst(a, $urandom_range(1, 4));
        end
        // A flood of writes against a stalled slave is read back afterwards
        hold = 1'b1;
        fork
            begin
                repeat (60) @(posedge mem_master);
                hold = 1'b0;
            end
        join_none
        for (int i = 0; i < 40; i++)
        begin
            write_burst(16'h2000 + addr_t'(i), 1);
        end
        write_burst(16'h2028, 4);
        write_burst(16'h202c, 4);
        for (int i = 0; i < 12; i++)
        begin
            read_burst(16'h2000 + addr_t'(4 * i), 4);
        end
        // Back-to-back 4-beat reads to press on the response FIFO
        for (int i = 0; i < 12; i++)
        begin
            read_burst(16'h3000 + addr_t'(4 * i), 4);
        end
        while (exp_p.size() > 0 || exp_af.size() > 0)
        begin
            @(posedge mem_master);
        end
        count_p_chk: assert (wb_p == write_beats_issued)
            else report_mismatch("write_beats(dut_i)", write_beats_issued, wb_p);
        count_af_chk: assert (wb_af == write_beats_issued)
            else report_mismatch("write_beats(dut_af_i)", write_beats_issued, wb_af);
        repeat (10) @(posedge mem_master);
        $display("Test OK");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
source/avmm_cross_pkg.sv
source/async_fifo.sv
source/avmm_clock_crossing_bridge.sv
source/avmm_async_shim.sv
test/avmm_mem_model.sv
test/tb_avmm_cross.sv
